// File: Makefile
TOP := tb_tlb_subsystem

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		-f tlb_subsystem.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee sim.log
	@if grep -q "TEST FAILED" sim.log; then exit 1; fi
	@grep -q "TEST PASSED" sim.log

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps \
		-f tlb_subsystem.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// File: l1_tlb.sv
/*
 * private fully associative L1 TLB
 * same-cycle lookup, refilled by the shared TLB
 */
module l1_tlb import tlb_pkg::*; #(
    parameter int L1_ENTRIES = 4
) (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            flush_i,
    input  logic            enable_i,   // translation on for this side
    input  logic            access_i,
    input  logic [VLEN-1:0] vaddr_i,
    input  asid_t           asid_i,
    input  tlb_update_t     update_i,   // from shared tlb
    output logic            hit_o,
    output logic [PLEN-1:0] paddr_o,
    output logic            miss_o
);

    localparam int IDX_W = $clog2(L1_ENTRIES);

    vpn_t                  vpn_q   [L1_ENTRIES];
    asid_t                 asid_q  [L1_ENTRIES];
    logic                  is_4m_q [L1_ENTRIES];
    pte_t                  pte_q   [L1_ENTRIES];
    logic [L1_ENTRIES-1:0] valid_q;

    vpn_t                  lookup_vpn;
    logic [L1_ENTRIES-1:0] match;
    logic [IDX_W-1:0]      hit_idx;
    logic [IDX_W-1:0]      inv_idx;
    logic [IDX_W-1:0]      rr_q;        // round robin victim
    logic [IDX_W-1:0]      repl_idx;
    logic                  all_valid;

    assign lookup_vpn = vaddr_i[VLEN-1:12];

    //////////////////////////////////////////////////////////////////////
    // parallel compare
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        hit_idx = '0;
        for (int i = 0; i < L1_ENTRIES; i++) begin
            match[i] = valid_q[i]
                && (vpn_q[i].vpn1 == lookup_vpn.vpn1)
                && ((asid_q[i] == asid_i) || pte_q[i].g)
                && (is_4m_q[i] || (vpn_q[i].vpn0 == lookup_vpn.vpn0));
            if (match[i]) begin
                hit_idx = IDX_W'(i);
            end
        end
    end

    assign hit_o  = access_i & enable_i & (|match);
    assign miss_o = access_i & enable_i & ~(|match);

    // megapage takes ppn0 from the vaddr
    assign paddr_o = {pte_q[hit_idx].ppn1,
                      is_4m_q[hit_idx] ? lookup_vpn.vpn0 : pte_q[hit_idx].ppn0,
                      vaddr_i[11:0]};

    //////////////////////////////////////////////////////////////////////
    // refill slot
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        inv_idx = '0;
        for (int i = L1_ENTRIES - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                inv_idx = IDX_W'(i);   // lowest free entry
            end
        end
    end

    assign all_valid = &valid_q;
    assign repl_idx  = all_valid ? rr_q : inv_idx;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
            rr_q    <= '0;
        end else if (flush_i) begin
            valid_q <= '0;
        end else if (update_i.valid) begin
            valid_q[repl_idx] <= 1'b1;
            if (all_valid) begin
                rr_q <= (rr_q == IDX_W'(L1_ENTRIES - 1)) ? '0 : rr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (update_i.valid && !flush_i) begin
            vpn_q[repl_idx]   <= update_i.vpn;
            asid_q[repl_idx]  <= update_i.asid;
            is_4m_q[repl_idx] <= update_i.is_4m;
            pte_q[repl_idx]   <= update_i.pte;
        end
    end

endmodule

// File: shared_tlb.sv
/*
 * set associative shared TLB behind the instruction and data L1 TLBs
 * serves one L1 miss at a time, refills the L1 on hit, asks for a walk on miss
 */
module shared_tlb import tlb_pkg::*; #(
    parameter int SHARED_DEPTH = 64,
    parameter int SHARED_WAYS  = 2
) (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            flush_i,
    input  asid_t           asid_i,
    input  logic            itlb_miss_i,
    input  logic [VLEN-1:0] itlb_vaddr_i,
    input  logic            dtlb_miss_i,
    input  logic [VLEN-1:0] dtlb_vaddr_i,
    output tlb_update_t     itlb_update_o,
    output tlb_update_t     dtlb_update_o,
    output logic            walk_req_o,
    output logic [VLEN-1:0] walk_vaddr_o,
    input  tlb_update_t     refill_i      // walker fill, single-cycle strobe
);

    localparam int SET_W = $clog2(SHARED_DEPTH);
    localparam int WAY_W = $clog2(SHARED_WAYS);

    typedef struct packed {
        asid_t asid;
        vpn_t  vpn;
        logic  is_4m;
    } tag_t;

    logic                                     lookup_go;
    logic [VLEN-1:0]                          lookup_vaddr;
    logic [SET_W-1:0]                         lookup_set;
    logic                                     lookup_q;      // compare stage busy
    logic                                     walk_pend_q;   // walk out, wait for refill
    logic                                     req_dside_q;
    logic [VLEN-1:0]                          req_vaddr_q;
    asid_t                                    req_asid_q;
    vpn_t                                     req_vpn;

    logic [SHARED_DEPTH-1:0][SHARED_WAYS-1:0] valid_q;
    logic [SHARED_WAYS-1:0]                   rd_valid_q;
    logic [SET_W-1:0]                         arr_addr;
    logic [SHARED_WAYS-1:0]                   wr_en;
    tag_t                                     tag_wdata;
    tag_t                                     tag_rd [SHARED_WAYS];
    pte_t                                     pte_rd [SHARED_WAYS];

    logic [SHARED_WAYS-1:0]                   way_hit;
    logic                                     shared_hit;
    tlb_update_t                              upd;

    logic [SET_W-1:0]                         refill_set;
    logic [SHARED_WAYS-1:0]                   set_valid;
    logic [WAY_W-1:0]                         inv_way;
    logic [WAY_W-1:0]                         repl_way;
    logic [7:0]                               lfsr_q;

    //////////////////////////////////////////////////////////////////////
    // miss arbitration, data side first
    //////////////////////////////////////////////////////////////////////
    // a refill or flush in the same cycle drops the miss, the L1 retries
    assign lookup_go = (itlb_miss_i | dtlb_miss_i) & ~lookup_q & ~walk_pend_q
                       & ~refill_i.valid & ~flush_i;
    assign lookup_vaddr = dtlb_miss_i ? dtlb_vaddr_i : itlb_vaddr_i;
    assign lookup_set   = lookup_vaddr[12 +: SET_W];
    assign refill_set   = refill_i.vpn[SET_W-1:0];
    assign arr_addr     = refill_i.valid ? refill_set : lookup_set;  // write wins

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            lookup_q    <= 1'b0;
            walk_pend_q <= 1'b0;
            rd_valid_q  <= '0;
        end else begin
            lookup_q <= lookup_go;
            if (lookup_go) begin
                rd_valid_q <= valid_q[lookup_set];   // sampled with the array read
            end
            if (flush_i || refill_i.valid) begin
                walk_pend_q <= 1'b0;
            end else if (walk_req_o) begin
                walk_pend_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (lookup_go) begin
            req_vaddr_q <= lookup_vaddr;
            req_asid_q  <= asid_i;
            req_dside_q <= dtlb_miss_i;
        end
    end

    assign req_vpn = req_vaddr_q[VLEN-1:12];

    //////////////////////////////////////////////////////////////////////
    // tag compare, one cycle after the read
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        upd = '0;
        for (int w = 0; w < SHARED_WAYS; w++) begin
            way_hit[w] = rd_valid_q[w]
                && (tag_rd[w].vpn.vpn1 == req_vpn.vpn1)
                && ((tag_rd[w].asid == req_asid_q) || pte_rd[w].g)
                && (tag_rd[w].is_4m || (tag_rd[w].vpn.vpn0 == req_vpn.vpn0));
            if (way_hit[w]) begin
                upd.is_4m = tag_rd[w].is_4m;
                upd.pte   = pte_rd[w];
            end
        end
        upd.vpn  = req_vpn;
        upd.asid = req_asid_q;
    end

    assign shared_hit = lookup_q & (|way_hit);

    always_comb begin
        itlb_update_o       = upd;
        itlb_update_o.valid = shared_hit & ~req_dside_q;
        dtlb_update_o       = upd;
        dtlb_update_o.valid = shared_hit & req_dside_q;
    end

    assign walk_req_o   = lookup_q & ~(|way_hit);
    assign walk_vaddr_o = req_vaddr_q;

    //////////////////////////////////////////////////////////////////////
    // walker refill and replacement
    //////////////////////////////////////////////////////////////////////
    assign set_valid = valid_q[refill_set];

    always_comb begin
        inv_way = '0;
        for (int w = SHARED_WAYS - 1; w >= 0; w--) begin
            if (!set_valid[w]) begin
                inv_way = WAY_W'(w);
            end
        end
    end

    assign repl_way = (&set_valid) ? lfsr_q[WAY_W-1:0] : inv_way;

    always_comb begin
        wr_en = '0;
        if (refill_i.valid) begin
            wr_en[repl_way] = 1'b1;
        end
    end

    assign tag_wdata.asid  = refill_i.asid;
    assign tag_wdata.vpn   = refill_i.vpn;
    assign tag_wdata.is_4m = refill_i.is_4m;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
            lfsr_q  <= 8'h01;
        end else begin
            if (flush_i) begin
                valid_q <= '0;
            end else if (refill_i.valid) begin
                valid_q[refill_set][repl_way] <= 1'b1;
            end
            // x^8 + x^6 + x^5 + x^4 + 1, steps only when a valid way is evicted
            if (refill_i.valid && (&set_valid)) begin
                lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
            end
        end
    end

    for (genvar w = 0; w < SHARED_WAYS; w++) begin : gen_way
        tlb_sram #(
            .DEPTH     (SHARED_DEPTH),
            .payload_t (tag_t)
        ) i_tag_sram (
            .clk_i   (clk_i),
            .req_i   (lookup_go | wr_en[w]),
            .we_i    (wr_en[w]),
            .addr_i  (arr_addr),
            .wdata_i (tag_wdata),
            .rdata_o (tag_rd[w])
        );

        tlb_sram #(
            .DEPTH     (SHARED_DEPTH),
            .payload_t (pte_t)
        ) i_pte_sram (
            .clk_i   (clk_i),
            .req_i   (lookup_go | wr_en[w]),
            .we_i    (wr_en[w]),
            .addr_i  (arr_addr),
            .wdata_i (refill_i.pte),
            .rdata_o (pte_rd[w])
        );
    end

endmodule

// File: tb_tlb_subsystem.sv
/*
 * testbench for the sv32 translation subsystem
 * table driven lookups on both L1 TLBs, the page walker is modeled here
 */
module tb_tlb_subsystem import tlb_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int         PAGES   = 5;
    localparam int         RETRIES = 20;
    localparam logic [1:0] SIDE_I  = 2'd1;
    localparam logic [1:0] SIDE_D  = 2'd2;
    localparam logic [1:0] SIDE_ID = 2'd3;   // both sides at once

    typedef struct packed {
        logic [1:0]      side;
        logic            flush;       // pulse flush_i before the lookup
        logic [VLEN-1:0] ivaddr;
        logic [VLEN-1:0] dvaddr;
        asid_t           asid;
        logic            first_hit;   // hit in the first access cycle
        logic            walk;        // walk request expected
        logic [PLEN-1:0] exp_ipaddr;
        logic [PLEN-1:0] exp_dpaddr;
    } row_t;

    logic            clk_i;
    logic            rst_ni;
    logic            flush_i;
    logic            enable_translation_i;
    logic            en_ld_st_translation_i;
    asid_t           asid_i;
    logic            itlb_access_i;
    logic [VLEN-1:0] itlb_vaddr_i;
    logic            itlb_hit_o;
    logic [PLEN-1:0] itlb_paddr_o;
    logic            dtlb_access_i;
    logic [VLEN-1:0] dtlb_vaddr_i;
    logic            dtlb_hit_o;
    logic [PLEN-1:0] dtlb_paddr_o;
    logic            walk_req_o;
    logic [VLEN-1:0] walk_vaddr_o;
    logic            refill_valid_i;
    vpn_t            refill_vpn_i;
    asid_t           refill_asid_i;
    logic            refill_is_4m_i;
    pte_t            refill_pte_i;

    row_t        rows [$];
    vpn_t        pt_vpn [PAGES];   // page table of the walker model
    logic        pt_4m  [PAGES];
    logic        pt_g   [PAGES];
    logic [21:0] pt_ppn [PAGES];
    int          errors;
    int          checks;
    integer      seed;

    tlb_subsystem #(
        .L1_ENTRIES   (4),
        .SHARED_DEPTH (64),
        .SHARED_WAYS  (2)
    ) UUT (.*);

    always #2 clk_i = ~clk_i;

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////
    function automatic int find_page(input logic [VLEN-1:0] va);
        int idx;
        idx = -1;
        for (int i = 0; i < PAGES; i++) begin
            if ((pt_vpn[i].vpn1 == va[31:22]) && (pt_4m[i] || (pt_vpn[i].vpn0 == va[21:12]))) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    // megapages keep vpn0 of the address
    function automatic logic [PLEN-1:0] expected_paddr(input logic [VLEN-1:0] va);
        int idx;
        idx = find_page(va);
        if (idx < 0) begin
            return '0;   // side not used
        end
        if (pt_4m[idx]) begin
            return {pt_ppn[idx][21:10], va[21:12], va[11:0]};
        end
        return {pt_ppn[idx], va[11:0]};
    endfunction

    function automatic void add_row(input logic [1:0] side, input logic flush,
                                    input logic [VLEN-1:0] iva, input logic [VLEN-1:0] dva,
                                    input asid_t asid, input logic first_hit,
                                    input logic walk);
        row_t r;
        r.side       = side;
        r.flush      = flush;
        r.ivaddr     = iva;
        r.dvaddr     = dva;
        r.asid       = asid;
        r.first_hit  = first_hit;
        r.walk       = walk;
        r.exp_ipaddr = expected_paddr(iva);
        r.exp_dpaddr = expected_paddr(dva);
        rows.push_back(r);
    endfunction

    function automatic void check_value(input string name, input logic [PLEN-1:0] got,
                                        input logic [PLEN-1:0] exp);
        checks++;
        if (got !== exp) begin
            $display("[ERROR] %0t %s: got %0h expected %0h", $time, name, got, exp);
            errors++;
        end
    endfunction

    //////////////////////////////////////////////////////////////////////
    // walker model, one refill strobe per walk request
    //////////////////////////////////////////////////////////////////////
    task automatic answer_walk(input logic [VLEN-1:0] va);
        int   idx;
        pte_t pte;
        idx = find_page(va);
        if (idx < 0) begin
            $display("walker got a request for unmapped vaddr %h", va);
            errors++;
            idx = 0;   // still refill so the shared TLB unblocks
        end
        pte      = '0;
        pte.ppn1 = pt_ppn[idx][21:10];
        pte.ppn0 = pt_ppn[idx][9:0];
        pte.g    = pt_g[idx];
        {pte.d, pte.a, pte.x, pte.w, pte.r, pte.v} = 6'b111111;
        @(posedge clk_i);
        refill_valid_i <= 1'b1;
        refill_vpn_i   <= va[VLEN-1:12];
        refill_asid_i  <= asid_i;
        refill_is_4m_i <= pt_4m[idx];
        refill_pte_i   <= pte;
        @(posedge clk_i);
        refill_valid_i <= 1'b0;
    endtask

    task automatic apply_row(input int n, input row_t r);
        logic            got_i;
        logic            got_d;
        logic            first_i;
        logic            first_d;
        logic            walked;
        logic [PLEN-1:0] pa_i;
        logic [PLEN-1:0] pa_d;
        logic [VLEN-1:0] exp_walk_va;
        int              cyc;
        got_i   = !r.side[0];
        got_d   = !r.side[1];
        first_i = 1'b0;
        first_d = 1'b0;
        walked  = 1'b0;
        pa_i    = '0;
        pa_d    = '0;
        if (r.flush) begin
            @(posedge clk_i);
            flush_i <= 1'b1;
            @(posedge clk_i);
            flush_i <= 1'b0;
        end
        @(posedge clk_i);
        asid_i        <= r.asid;
        itlb_access_i <= r.side[0];
        itlb_vaddr_i  <= r.ivaddr;
        dtlb_access_i <= r.side[1];
        dtlb_vaddr_i  <= r.dvaddr;
        cyc = 0;
        while (!(got_i && got_d) && (cyc < RETRIES)) begin
            @(negedge clk_i);   // combinational hit settled
            if (cyc == 0) begin
                first_i = itlb_hit_o;
                first_d = dtlb_hit_o;
            end
            if (!got_i && itlb_hit_o) begin
                got_i = 1'b1;
                pa_i  = itlb_paddr_o;
            end
            if (!got_d && dtlb_hit_o) begin
                got_d = 1'b1;
                pa_d  = dtlb_paddr_o;
            end
            if (walk_req_o) begin
                walked = 1'b1;
                // a pending data miss goes first
                exp_walk_va = (r.side[1] && !got_d) ? r.dvaddr : r.ivaddr;
                check_value("walk_vaddr_o", walk_vaddr_o, exp_walk_va);
                answer_walk(walk_vaddr_o);
            end
            cyc++;
        end
        @(posedge clk_i);
        itlb_access_i <= 1'b0;
        dtlb_access_i <= 1'b0;
        if (!(got_i && got_d)) begin
            $display("row %0d: lookup still missing after %0d retries", n, RETRIES);
            errors++;
        end
        if (r.side[0] && got_i) begin
            check_value("itlb_paddr_o", pa_i, r.exp_ipaddr);
        end
        if (r.side[1] && got_d) begin
            check_value("dtlb_paddr_o", pa_d, r.exp_dpaddr);
        end
        // final results only when both sides compete
        if (r.side == SIDE_I) begin
            check_value("itlb_hit_o", first_i, r.first_hit);
        end else if (r.side == SIDE_D) begin
            check_value("dtlb_hit_o", first_d, r.first_hit);
        end
        if (r.side != SIDE_ID) begin
            check_value("walk_req_o", walked, r.walk);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////
    initial begin
        seed                   = 32'h0d56dd8c;
        errors                 = 0;
        checks                 = 0;
        clk_i                  = 1'b0;
        rst_ni                 = 1'b1;
        flush_i                = 1'b0;
        enable_translation_i   = 1'b1;
        en_ld_st_translation_i = 1'b1;
        asid_i                 = '0;
        itlb_access_i          = 1'b0;
        itlb_vaddr_i           = '0;
        dtlb_access_i          = 1'b0;
        dtlb_vaddr_i           = '0;
        refill_valid_i         = 1'b0;
        refill_vpn_i           = '0;
        refill_asid_i          = '0;
        refill_is_4m_i         = 1'b0;
        refill_pte_i           = '0;

        pt_vpn[0] = {10'h001, 10'h005};   // 4k page
        pt_vpn[1] = {10'h040, 10'h000};   // megapage
        pt_vpn[2] = {10'h080, 10'h009};   // global
        pt_vpn[3] = {10'h0c0, 10'h00d};
        pt_vpn[4] = {10'h100, 10'h00e};
        pt_4m     = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0};
        pt_g      = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
        for (int i = 0; i < PAGES; i++) begin
            pt_ppn[i] = 22'($random(seed));
        end

        add_row(SIDE_I,  1'b0, 32'h0040_5123, 32'h0,         9'd1, 1'b0, 1'b1);
        add_row(SIDE_I,  1'b0, 32'h0040_5123, 32'h0,         9'd1, 1'b1, 1'b0);
        add_row(SIDE_D,  1'b0, 32'h0,         32'h0040_5abc, 9'd1, 1'b0, 1'b0);
        add_row(SIDE_D,  1'b0, 32'h0,         32'h0040_5abc, 9'd1, 1'b1, 1'b0);
        add_row(SIDE_D,  1'b0, 32'h0,         32'h1001_1040, 9'd1, 1'b0, 1'b1);
        add_row(SIDE_D,  1'b0, 32'h0,         32'h102a_7ff8, 9'd1, 1'b1, 1'b0);
        add_row(SIDE_I,  1'b0, 32'h0040_5123, 32'h0,         9'd2, 1'b0, 1'b1);
        add_row(SIDE_I,  1'b0, 32'h2000_9010, 32'h0,         9'd1, 1'b0, 1'b1);
        add_row(SIDE_I,  1'b0, 32'h2000_9010, 32'h0,         9'd3, 1'b1, 1'b0);
        add_row(SIDE_ID, 1'b0, 32'h4000_e300, 32'h3000_d200, 9'd1, 1'b0, 1'b0);
        add_row(SIDE_I,  1'b1, 32'h0040_5123, 32'h0,         9'd1, 1'b0, 1'b1);

        #1 rst_ni = 1'b0;
        repeat (8) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(posedge clk_i);

        foreach (rows[i]) begin
            apply_row(i, rows[i]);
        end
        repeat (2) @(posedge clk_i);

        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, UUT.i_chk.fail_cnt);
        if ((errors == 0) && (UUT.i_chk.fail_cnt == 0)) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: tlb_pkg.sv
/*
 * sv32 translation types shared by the L1 TLBs, the shared TLB and the testbench
 * address widths, leaf PTE layout and the refill record
 */
package tlb_pkg;

    localparam int VLEN = 32;   // virtual address
    localparam int PLEN = 34;   // sv32 physical address

    // virtual page number, vpn1 selects the megapage
    typedef struct packed {
        logic [9:0] vpn1;
        logic [9:0] vpn0;
    } vpn_t;

    typedef logic [8:0] asid_t;

    // leaf pte, ppn above the flag bits
    typedef struct packed {
        logic [11:0] ppn1;
        logic [9:0]  ppn0;
        logic        d;
        logic        a;
        logic        g;     // global, matches any asid
        logic        u;
        logic        x;
        logic        w;
        logic        r;
        logic        v;
    } pte_t;

    //////////////////////////////////////////////////////////////////////
    // one TLB fill, used shared->L1 and walker->shared
    //////////////////////////////////////////////////////////////////////
    typedef struct packed {
        logic  valid;
        vpn_t  vpn;
        asid_t asid;
        logic  is_4m;       // megapage, vpn0 ignored on match
        pte_t  pte;
    } tlb_update_t;

endpackage

// File: tlb_sram.sv
/*
 * single-port TLB array, one cycle read latency
 * read data holds until the next read request
 */
module tlb_sram #(
    parameter int  DEPTH     = 64,
    parameter type payload_t = logic [31:0]
) (
    input  logic                     clk_i,
    input  logic                     req_i,
    input  logic                     we_i,
    input  logic [$clog2(DEPTH)-1:0] addr_i,
    input  payload_t                 wdata_i,
    output payload_t                 rdata_o
);

    payload_t mem_q [DEPTH];
    payload_t rdata_q;

    always_ff @(posedge clk_i) begin
        if (req_i) begin
            if (we_i) begin
                mem_q[addr_i] <= wdata_i;
            end else begin
                rdata_q <= mem_q[addr_i];   // registered read
            end
        end
    end

    assign rdata_o = rdata_q;

endmodule

// File: tlb_subsystem.f
tlb_pkg.sv
tlb_sram.sv
l1_tlb.sv
shared_tlb.sv
tlb_subsystem.sv
tlb_subsystem_chk.sv
tb_tlb_subsystem.sv

// File: tlb_subsystem.sv
/*
 * sv32 two-level translation, instruction and data L1 TLBs over a shared TLB
 * walk requests leave at the top, the walker refills through the refill port
 */
module tlb_subsystem import tlb_pkg::*; #(
    parameter int L1_ENTRIES   = 4,
    parameter int SHARED_DEPTH = 64,
    parameter int SHARED_WAYS  = 2
) (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            flush_i,
    input  logic            enable_translation_i,
    input  logic            en_ld_st_translation_i,
    input  asid_t           asid_i,
    input  logic            itlb_access_i,
    input  logic [VLEN-1:0] itlb_vaddr_i,
    output logic            itlb_hit_o,
    output logic [PLEN-1:0] itlb_paddr_o,
    input  logic            dtlb_access_i,
    input  logic [VLEN-1:0] dtlb_vaddr_i,
    output logic            dtlb_hit_o,
    output logic [PLEN-1:0] dtlb_paddr_o,
    output logic            walk_req_o,
    output logic [VLEN-1:0] walk_vaddr_o,
    input  logic            refill_valid_i,
    input  vpn_t            refill_vpn_i,
    input  asid_t           refill_asid_i,
    input  logic            refill_is_4m_i,
    input  pte_t            refill_pte_i
);

    logic        itlb_miss;
    logic        dtlb_miss;
    tlb_update_t itlb_update;
    tlb_update_t dtlb_update;
    tlb_update_t refill;

    assign refill = '{valid: refill_valid_i, vpn: refill_vpn_i, asid: refill_asid_i,
                      is_4m: refill_is_4m_i, pte: refill_pte_i};

    l1_tlb #(.L1_ENTRIES(L1_ENTRIES)) i_itlb (
        .clk_i(clk_i), .rst_ni(rst_ni), .flush_i(flush_i),
        .enable_i(enable_translation_i),
        .access_i(itlb_access_i), .vaddr_i(itlb_vaddr_i), .asid_i(asid_i),
        .update_i(itlb_update),
        .hit_o(itlb_hit_o), .paddr_o(itlb_paddr_o), .miss_o(itlb_miss)
    );

    l1_tlb #(.L1_ENTRIES(L1_ENTRIES)) i_dtlb (
        .clk_i(clk_i), .rst_ni(rst_ni), .flush_i(flush_i),
        .enable_i(en_ld_st_translation_i),
        .access_i(dtlb_access_i), .vaddr_i(dtlb_vaddr_i), .asid_i(asid_i),
        .update_i(dtlb_update),
        .hit_o(dtlb_hit_o), .paddr_o(dtlb_paddr_o), .miss_o(dtlb_miss)
    );

    shared_tlb #(
        .SHARED_DEPTH (SHARED_DEPTH),
        .SHARED_WAYS  (SHARED_WAYS)
    ) i_shared_tlb (
        .clk_i(clk_i), .rst_ni(rst_ni), .flush_i(flush_i), .asid_i(asid_i),
        .itlb_miss_i(itlb_miss), .itlb_vaddr_i(itlb_vaddr_i),
        .dtlb_miss_i(dtlb_miss), .dtlb_vaddr_i(dtlb_vaddr_i),
        .itlb_update_o(itlb_update), .dtlb_update_o(dtlb_update),
        .walk_req_o(walk_req_o), .walk_vaddr_o(walk_vaddr_o),
        .refill_i(refill)
    );

endmodule

// File: tlb_subsystem_chk.sv
/*
 * protocol assertions on the translation subsystem top level
 */
module tlb_subsystem_chk (
    input logic clk_i,
    input logic rst_ni,
    input logic itlb_access_i,
    input logic itlb_hit_i,
    input logic dtlb_access_i,
    input logic dtlb_hit_i,
    input logic walk_req_i
);

    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_cnt = 0;   // failed assertions so far

    a_no_walk_in_reset: assert property (@(posedge clk_i) !rst_ni |-> !walk_req_i)
        else begin
            $error("walk request raised while in reset");
            fail_cnt++;
        end

    a_itlb_hit_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
        itlb_access_i |-> !$isunknown(itlb_hit_i))
        else begin
            $error("itlb hit unknown during an access");
            fail_cnt++;
        end

    a_dtlb_hit_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
        dtlb_access_i |-> !$isunknown(dtlb_hit_i))
        else begin
            $error("dtlb hit unknown during an access");
            fail_cnt++;
        end

    // one compare cycle per lookup, so a walk request is a single pulse
    a_walk_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
        walk_req_i |=> !walk_req_i)
        else begin
            $error("walk request held for two cycles");
            fail_cnt++;
        end

endmodule

bind tlb_subsystem tlb_subsystem_chk i_chk (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .itlb_access_i (itlb_access_i),
    .itlb_hit_i    (itlb_hit_o),
    .dtlb_access_i (dtlb_access_i),
    .dtlb_hit_i    (dtlb_hit_o),
    .walk_req_i    (walk_req_o)
);
